// File: rtl/alu_consts.svh
// Fixed RV64 widths and base ISA encodings only; RS_DEPTH must be a power of two
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define XLEN            64
`define ILEN            32
`define RS_DEPTH        8

`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP_32       7'b0111011
`define OPC_OP_IMM_32   7'b0011011

`define F3_ADD_SUB      3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRL_SRA      3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000
`define F6_BASE         6'b000000
`define F6_ALT          6'b010000

`endif

// File: rtl/alu_pkg.sv
// Types for the ALU unit; widths come from the shared defines and the index is log2(RS_DEPTH)
`include "alu_consts.svh"

package alu_pkg;

    // ------------------------------------------------
    // Common fields
    // ------------------------------------------------

    // Reservation station entry index
    typedef logic [$clog2(`RS_DEPTH)-1:0] entry_idx_t;

    // ALU operation codes
    // ALU_ILLEGAL marks any encoding the unit does not execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDW,
        ALU_SUB,
        ALU_SUBW,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SLLW,
        ALU_SRL,
        ALU_SRLW,
        ALU_SRA,
        ALU_SRAW,
        ALU_SLT,
        ALU_SLTU,
        ALU_ILLEGAL
    } alu_ctl_t;

    // ------------------------------------------------
    // Pipeline payloads
    // ------------------------------------------------

    // Issued by the reservation station
    typedef struct packed {
        logic [`ILEN-1:0] instr;      // raw instruction word
        logic [`XLEN-1:0] rs1;        // first source value
        logic [`XLEN-1:0] rs2;        // second source value
        entry_idx_t       entry_idx;  // station slot
    } alu_req_t;

    // Held in the decode register
    typedef struct packed {
        alu_ctl_t         ctl;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;       // rs2 or sign-extended immediate
        entry_idx_t       entry_idx;
    } alu_dec_t;

    // Returned to the reservation station
    typedef struct packed {
        logic [`XLEN-1:0] res;
        entry_idx_t       entry_idx;
        logic             except_raised;  // illegal instruction
    } alu_resp_t;

endpackage

// File: rtl/spill_cell_flush.sv
// Two-entry skid register; ready_o is registered and flush drops both entries at once
`timescale 1ns/1ps

module spill_cell_flush #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  flush_i,

    // Upstream and downstream handshake
    input  logic  valid_i,
    input  logic  ready_i,
    output logic  valid_o,
    output logic  ready_o,

    // Payload
    input  DATA_T data_i,
    output DATA_T data_o
);

    // Slot state
    logic  main_valid;
    logic  skid_valid;
    DATA_T main_data;
    DATA_T skid_data;

    // Load controls
    logic  in_fire;
    logic  main_free;
    logic  main_load;
    logic  skid_load;

    // ------------------------------------------------
    // Slot control
    // ------------------------------------------------

    assign in_fire   = valid_i & ready_o;
    // Main slot empty or drained this cycle
    assign main_free = ~main_valid | ready_i;
    // Skid data has priority to keep order
    assign main_load = main_free & (skid_valid | in_fire);
    // Catch the extra item while the output stalls
    assign skid_load = ~main_free & in_fire;

    always_ff @(posedge clk_i or negedge arst_n_i) begin : ctl_reg
        if (!arst_n_i) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (flush_i) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // Skid full means no input was taken
            main_valid <= skid_valid | in_fire;
            skid_valid <= 1'b0;
        end else if (skid_load) begin
            skid_valid <= 1'b1;
        end
    end

    // ------------------------------------------------
    // Payload storage
    // ------------------------------------------------

    always_ff @(posedge clk_i) begin : data_reg
        if (main_load) begin
            main_data <= skid_valid ? skid_data : data_i;
        end
        if (skid_load) begin
            skid_data <= data_i;
        end
    end

    // Outputs
    assign valid_o = main_valid;
    assign data_o  = main_data;
    // Only free skid slot allows new input
    assign ready_o = ~skid_valid;

endmodule

// File: rtl/alu_decoder.sv
// RV64I integer ALU encodings only; anything else decodes to ALU_ILLEGAL
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_decoder (
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::alu_dec_t dec_o
);

    import alu_pkg::*;

    // Instruction fields
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [5:0]       funct6;
    logic [`XLEN-1:0] imm_sext;

    // Decode results
    alu_ctl_t         ctl;
    logic             use_imm;

    assign opcode   = req_i.instr[6:0];
    assign funct3   = req_i.instr[14:12];
    assign funct7   = req_i.instr[31:25];
    // RV64 immediate shifts keep a 6-bit shamt
    assign funct6   = req_i.instr[31:26];
    // I-type immediate
    assign imm_sext = {{(`XLEN-12){req_i.instr[31]}}, req_i.instr[31:20]};

    // ------------------------------------------------
    // Opcode and function match
    // ------------------------------------------------

    always_comb begin : decode
        ctl     = ALU_ILLEGAL;
        use_imm = 1'b0;

        case (opcode)
            // Register forms
            `OPC_OP: begin
                case ({funct7, funct3})
                    {`F7_BASE, `F3_ADD_SUB}: ctl = ALU_ADD;
                    {`F7_ALT,  `F3_ADD_SUB}: ctl = ALU_SUB;
                    {`F7_BASE, `F3_SLL}:     ctl = ALU_SLL;
                    {`F7_BASE, `F3_SLT}:     ctl = ALU_SLT;
                    {`F7_BASE, `F3_SLTU}:    ctl = ALU_SLTU;
                    {`F7_BASE, `F3_XOR}:     ctl = ALU_XOR;
                    {`F7_BASE, `F3_SRL_SRA}: ctl = ALU_SRL;
                    {`F7_ALT,  `F3_SRL_SRA}: ctl = ALU_SRA;
                    {`F7_BASE, `F3_OR}:      ctl = ALU_OR;
                    {`F7_BASE, `F3_AND}:     ctl = ALU_AND;
                    default:                 ctl = ALU_ILLEGAL;
                endcase
            end

            // Immediate forms
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    `F3_ADD_SUB: ctl = ALU_ADD;
                    `F3_SLT:     ctl = ALU_SLT;
                    `F3_SLTU:    ctl = ALU_SLTU;
                    `F3_XOR:     ctl = ALU_XOR;
                    `F3_OR:      ctl = ALU_OR;
                    `F3_AND:     ctl = ALU_AND;
                    `F3_SLL: begin
                        if (funct6 == `F6_BASE) begin
                            ctl = ALU_SLL;
                        end
                    end
                    `F3_SRL_SRA: begin
                        if (funct6 == `F6_BASE) begin
                            ctl = ALU_SRL;
                        end else if (funct6 == `F6_ALT) begin
                            ctl = ALU_SRA;
                        end
                    end
                    default:     ctl = ALU_ILLEGAL;
                endcase
            end

            // Word register forms
            `OPC_OP_32: begin
                case ({funct7, funct3})
                    {`F7_BASE, `F3_ADD_SUB}: ctl = ALU_ADDW;
                    {`F7_ALT,  `F3_ADD_SUB}: ctl = ALU_SUBW;
                    {`F7_BASE, `F3_SLL}:     ctl = ALU_SLLW;
                    {`F7_BASE, `F3_SRL_SRA}: ctl = ALU_SRLW;
                    {`F7_ALT,  `F3_SRL_SRA}: ctl = ALU_SRAW;
                    default:                 ctl = ALU_ILLEGAL;
                endcase
            end

            // Word immediate forms
            // funct7 covers shamt[5] so amounts of 32 or more fall out
            `OPC_OP_IMM_32: begin
                use_imm = 1'b1;
                case (funct3)
                    `F3_ADD_SUB: ctl = ALU_ADDW;
                    `F3_SLL: begin
                        if (funct7 == `F7_BASE) begin
                            ctl = ALU_SLLW;
                        end
                    end
                    `F3_SRL_SRA: begin
                        if (funct7 == `F7_BASE) begin
                            ctl = ALU_SRLW;
                        end else if (funct7 == `F7_ALT) begin
                            ctl = ALU_SRAW;
                        end
                    end
                    default:     ctl = ALU_ILLEGAL;
                endcase
            end

            default: ctl = ALU_ILLEGAL;
        endcase
    end

    // ------------------------------------------------
    // Operand select
    // ------------------------------------------------

    assign dec_o.ctl       = ctl;
    assign dec_o.op_a      = req_i.rs1;
    assign dec_o.op_b      = use_imm ? imm_sext : req_i.rs2;
    assign dec_o.entry_idx = req_i.entry_idx;

endmodule

// File: rtl/alu.sv
// Purely combinational RV64 ALU; word forms use the low 32 bits and sign-extend
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu (
    input  alu_pkg::alu_ctl_t ctl_i,
    input  logic [`XLEN-1:0]  op_a_i,
    input  logic [`XLEN-1:0]  op_b_i,
    output logic [`XLEN-1:0]  res_o,
    output logic              except_raised_o
);

    import alu_pkg::*;

    // Shift amounts
    logic [5:0]       shamt;
    logic [4:0]       shamt_w;

    // Word path
    logic [31:0]      word_res;
    logic [`XLEN-1:0] word_sext;

    // Compare results
    logic             lt_s;
    logic             lt_u;

    // 6 bits for XLEN shifts and 5 for word shifts
    assign shamt   = op_b_i[5:0];
    assign shamt_w = op_b_i[4:0];

    assign lt_s = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u = op_a_i < op_b_i;

    // ------------------------------------------------
    // Word operations
    // ------------------------------------------------

    always_comb begin : word_ops
        case (ctl_i)
            ALU_ADDW: word_res = op_a_i[31:0] + op_b_i[31:0];
            ALU_SUBW: word_res = op_a_i[31:0] - op_b_i[31:0];
            ALU_SLLW: word_res = op_a_i[31:0] << shamt_w;
            ALU_SRLW: word_res = op_a_i[31:0] >> shamt_w;
            // Arithmetic shift on the low word only
            ALU_SRAW: word_res = $signed(op_a_i[31:0]) >>> shamt_w;
            default:  word_res = '0;
        endcase
    end

    // Bit 31 fills the upper half
    assign word_sext = {{(`XLEN-32){word_res[31]}}, word_res};

    // ------------------------------------------------
    // Result select
    // ------------------------------------------------

    always_comb begin : alu_ops
        res_o           = '0;
        except_raised_o = 1'b0;

        case (ctl_i)
            ALU_ADD:  res_o = op_a_i + op_b_i;
            ALU_SUB:  res_o = op_a_i - op_b_i;
            ALU_AND:  res_o = op_a_i & op_b_i;
            ALU_OR:   res_o = op_a_i | op_b_i;
            ALU_XOR:  res_o = op_a_i ^ op_b_i;
            ALU_SLL:  res_o = op_a_i << shamt;
            ALU_SRL:  res_o = op_a_i >> shamt;
            ALU_SRA:  res_o = $signed(op_a_i) >>> shamt;

            // Set-less-than gives 0 or 1
            ALU_SLT:  res_o = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res_o = {{(`XLEN-1){1'b0}}, lt_u};

            // All word forms share the sign extension
            ALU_ADDW,
            ALU_SUBW,
            ALU_SLLW,
            ALU_SRLW,
            ALU_SRAW: res_o = word_sext;

            // Zero result with the exception flag
            ALU_ILLEGAL: begin
                res_o           = '0;
                except_raised_o = 1'b1;
            end
        endcase
    end

endmodule

// File: rtl/alu_unit.sv
// Two register stages from request to response; flush drops every item in flight
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_unit (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               flush_i,

    // Request from the reservation station
    input  logic               valid_i,
    output logic               ready_o,
    input  alu_pkg::alu_req_t  req_i,

    // Response to the reservation station
    output logic               valid_o,
    input  logic               ready_i,
    output alu_pkg::alu_resp_t resp_o
);

    import alu_pkg::*;

    // Decode stage
    alu_dec_t         dec_d;
    alu_dec_t         dec_q;
    logic             dec_valid;
    logic             dec_ready;

    // Execute stage
    logic [`XLEN-1:0] alu_res;
    logic             alu_except;
    alu_resp_t        resp_d;

    // ------------------------------------------------
    // Decode and decode register
    // ------------------------------------------------

    alu_decoder u_decoder (
        .req_i (req_i),
        .dec_o (dec_d)
    );

    spill_cell_flush #(
        .DATA_T (alu_dec_t)
    ) u_dec_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .valid_i  (valid_i),
        .ready_i  (dec_ready),
        .valid_o  (dec_valid),
        .ready_o  (ready_o),
        .data_i   (dec_d),
        .data_o   (dec_q)
    );

    // ------------------------------------------------
    // Execute and result register
    // ------------------------------------------------

    alu u_alu (
        .ctl_i           (dec_q.ctl),
        .op_a_i          (dec_q.op_a),
        .op_b_i          (dec_q.op_b),
        .res_o           (alu_res),
        .except_raised_o (alu_except)
    );

    // Entry index rides along with the result
    assign resp_d.res           = alu_res;
    assign resp_d.entry_idx     = dec_q.entry_idx;
    assign resp_d.except_raised = alu_except;

    spill_cell_flush #(
        .DATA_T (alu_resp_t)
    ) u_out_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .valid_i  (dec_valid),
        .ready_i  (ready_i),
        .valid_o  (valid_o),
        .ready_o  (dec_ready),
        .data_i   (resp_d),
        .data_o   (resp_o)
    );

endmodule

// File: verif/alu_model.svh
// Reference model for the RV64 ALU unit; assumes alu_pkg is imported by the including module
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// R-type word with fixed register numbers
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
endfunction

// I-type word
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [6:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc};
endfunction

// Expected response straight from the ISA rules
function automatic alu_resp_t model_resp(input alu_req_t r);
    alu_resp_t  e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] w;
    logic       ill;
    opc = r.instr[6:0];
    f3  = r.instr[14:12];
    f7  = r.instr[31:25];
    a   = r.rs1;
    b   = (opc == `OPC_OP_IMM || opc == `OPC_OP_IMM_32) ?
          {{52{r.instr[31]}}, r.instr[31:20]} : r.rs2;
    ill = 1'b0;
    e.res = '0;
    e.entry_idx = r.entry_idx;
    if (opc == `OPC_OP || opc == `OPC_OP_IMM) begin
        // Immediate shifts check only the top 6 bits
        if (opc == `OPC_OP_IMM && f3 != 3'd1 && f3 != 3'd5) f7 = 7'd0;
        if (opc == `OPC_OP_IMM) f7[0] = 1'b0;
        case ({f7, f3})
            {7'h00, 3'd0}: e.res = a + b;
            // Only the register form reaches here
            {7'h20, 3'd0}: e.res = a - b;
            {7'h00, 3'd1}: e.res = a << b[5:0];
            {7'h00, 3'd2}: e.res = {63'd0, $signed(a) < $signed(b)};
            {7'h00, 3'd3}: e.res = {63'd0, a < b};
            {7'h00, 3'd4}: e.res = a ^ b;
            {7'h00, 3'd5}: e.res = a >> b[5:0];
            {7'h20, 3'd5}: e.res = $signed(a) >>> b[5:0];
            {7'h00, 3'd6}: e.res = a | b;
            {7'h00, 3'd7}: e.res = a & b;
            default:       ill = 1'b1;
        endcase
    end else if (opc == `OPC_OP_32 || opc == `OPC_OP_IMM_32) begin
        if (opc == `OPC_OP_IMM_32 && f3 == 3'd0) f7 = 7'd0;
        case ({f7, f3})
            {7'h00, 3'd0}: w = a[31:0] + b[31:0];
            {7'h20, 3'd0}: w = a[31:0] - b[31:0];
            {7'h00, 3'd1}: w = a[31:0] << b[4:0];
            {7'h00, 3'd5}: w = a[31:0] >> b[4:0];
            {7'h20, 3'd5}: w = $signed(a[31:0]) >>> b[4:0];
            default: begin
                w   = '0;
                ill = 1'b1;
            end
        endcase
        if (!ill) e.res = {{32{w[31]}}, w};
    end else begin
        ill = 1'b1;
    end
    if (ill) e.res = '0;
    e.except_raised = ill;
    return e;
endfunction

`endif

// File: verif/tb_alu_unit.sv
// Random testbench for alu_unit; checks by assertions against a queue of model responses
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_alu_unit;

    import alu_pkg::*;
    `include "alu_model.svh"

    localparam int TIMEOUT = 200;

    logic      clk_i;
    logic      arst_n_i;
    logic      flush_i;
    logic      valid_i;
    logic      ready_i;
    logic      ready_o;
    logic      valid_o;
    alu_req_t  req_i;
    alu_resp_t resp_o;

    // Scoreboard state
    alu_resp_t   exp_q[$];
    int          resp_count;
    logic        rand_ready;
    logic [31:0] lfsr_state;

    alu_unit dut0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .req_i    (req_i),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .resp_o   (resp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout(input string msg);
        $display("Timed out while waiting for %s", msg);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    // One LFSR step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // --------------------------------------------------
    // Scoreboard and assertions
    // --------------------------------------------------

    always @(posedge clk_i) begin : scoreboard
        if (!arst_n_i || flush_i) begin
            exp_q.delete();
        end else begin
            if (valid_o && ready_i) begin
                assert (exp_q.size() > 0)
                    else report_error("response with no request outstanding");
                assert (resp_o == exp_q[0])
                    else report_error($sformatf("got %h/%0d/%b exp %h/%0d/%b",
                        resp_o.res, resp_o.entry_idx, resp_o.except_raised,
                        exp_q[0].res, exp_q[0].entry_idx, exp_q[0].except_raised));
                void'(exp_q.pop_front());
                resp_count++;
            end
            if (valid_i && ready_o) exp_q.push_back(model_resp(req_i));
        end
    end

    // Stalled output holds
    assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(resp_o)))
        else report_error("output changed while stalled");

    always @(negedge clk_i) begin : ready_drive
        if (rand_ready) ready_i = (take_bits(2) != 0);
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    function automatic alu_req_t gen_req();
        alu_req_t    r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        f3  = 3'(take_bits(3));
        imm = 12'(take_bits(12));
        if (take_bits(2) == 0) imm[5:0] = 6'h3f;
        f7  = (take_bits(1) && (f3 == 3'd0 || f3 == 3'd5)) ? `F7_ALT : `F7_BASE;
        r.rs1 = take_bits(64);
        r.rs2 = take_bits(64);
        r.entry_idx = entry_idx_t'(take_bits($clog2(`RS_DEPTH)));
        case (take_bits(3))
            0, 1: r.instr = enc_r(f7, f3, `OPC_OP);
            2, 3: begin
                if (f3 == 3'd1 || f3 == 3'd5) imm[11:6] = {1'b0, f7[5], 4'd0};
                r.instr = enc_i(imm, f3, `OPC_OP_IMM);
            end
            4, 5: begin
                // Bit 31 set and a nonzero upper half
                r.rs1 = r.rs1 | 64'h0000_0001_8000_0000;
                f3 = take_bits(1) ? 3'd0 : (take_bits(1) ? 3'd1 : 3'd5);
                if (f3 == 3'd1) f7 = `F7_BASE;
                if (take_bits(1)) begin
                    r.instr = enc_r(f7, f3, `OPC_OP_32);
                end else begin
                    if (f3 != 3'd0) imm[11:5] = f7;
                    r.instr = enc_i(imm, f3, `OPC_OP_IMM_32);
                end
            end
            default: begin
                case (take_bits(2))
                    0: r.instr = enc_r(7'b0000001, f3, `OPC_OP);
                    1: r.instr = enc_r(`F7_BASE, 3'd7, `OPC_OP_32);
                    2: r.instr = enc_i({7'b0000001, imm[4:0]}, 3'd1, `OPC_OP_IMM_32);
                    default: r.instr = enc_i(imm, f3, 7'b0110111);
                endcase
            end
        endcase
        return r;
    endfunction

    // Called at a falling edge, returns at the falling edge after acceptance
    task automatic send_req(input alu_req_t r);
        int   waited;
        logic took;
        waited  = 0;
        took    = 1'b0;
        valid_i = 1'b1;
        req_i   = r;
        while (!took) begin
            took = ready_o;
            @(negedge clk_i);
            waited++;
            if (!took && waited > TIMEOUT) report_timeout("request acceptance");
        end
        valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || valid_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) report_timeout("the unit to drain");
        end
    endtask

    // Accept edge to transfer edge with ready_i high
    task automatic check_latency(input alu_req_t r);
        int cycles;
        send_req(r);
        cycles = 1;
        while (!valid_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) report_timeout("a response");
        end
        assert (cycles == 2) else report_error($sformatf("latency %0d, expected 2", cycles));
        drain();
    endtask

    initial begin : main
        int target;
        int waited;
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        req_i = '0;
        rand_ready = 1'b0;
        resp_count = 0;
        lfsr_state = 32'h5c9232b2;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        assert (!valid_o && ready_o) else report_error("bad state after reset");
        for (int k = 0; k < 4; k++) check_latency(gen_req());

        // Flush with the pipeline stalled
        // Four items fill both slots of both cells
        ready_i = 1'b0;
        for (int k = 0; k < 4; k++) send_req(gen_req());
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        ready_i = 1'b1;
        assert (!valid_o) else report_error("items left after flush");
        repeat (4) begin
            @(negedge clk_i);
            assert (!valid_o) else report_error("flushed item reappeared");
        end
        check_latency(gen_req());

        // Random traffic with back-pressure
        rand_ready = 1'b1;
        target = resp_count + 2000;
        waited = 0;
        while (resp_count < target) begin
            send_req(gen_req());
            repeat (take_bits(2) == 0 ? take_bits(2) : 0) @(negedge clk_i);
            waited++;
            if (waited > 20 * 2000) report_timeout("2000 responses");
        end
        rand_ready = 1'b0;
        ready_i = 1'b1;
        drain();

        // Reset in the middle of traffic
        // Decode skid is full so ready_o is low before reset
        ready_i = 1'b0;
        for (int k = 0; k < 4; k++) send_req(gen_req());
        arst_n_i = 1'b0;
        @(negedge clk_i);
        arst_n_i = 1'b1;
        ready_i = 1'b1;
        assert (!valid_o && ready_o) else report_error("bad state after second reset");
        check_latency(gen_req());
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
+incdir+verif
rtl/alu_pkg.sv
rtl/spill_cell_flush.sv
rtl/alu_decoder.sv
rtl/alu.sv
rtl/alu_unit.sv
verif/tb_alu_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the alu_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_alu_unit \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
